// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test completed successfully

SRCS := $(shell grep -v '^+' $(FLIST)) mem_macros.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_macros.svh"

module data_mem
  (input  logic               clk_i
  , input  logic              en_i
  , input  logic              we_i
  , input  mem_pkg::mem_addr_t addr_i
  , input  mem_pkg::word_t    wdata_i
  , output mem_pkg::word_t    rdata_o
  );

  import mem_pkg::*;

  word_t mem_q [`MEM_WORDS];
  word_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== dtlb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_macros.svh"

module dtlb
  (input  logic           clk_i
  , input  logic          reset_i
  , input  logic          flush_i
  , input  logic          lookup_v_i
  , input  mem_pkg::vtag_t lookup_vtag_i
  , output logic          hit_o
  , output logic          miss_o
  , output mem_pkg::pte_t pte_o
  , input  logic          fill_v_i
  , input  mem_pkg::vtag_t fill_vtag_i
  , input  mem_pkg::pte_t fill_pte_i
  );

  import mem_pkg::*;

  localparam int ptr_w = $clog2(`TLB_ENTRIES);

  vtag_t                   tag_q [`TLB_ENTRIES];
  pte_t                    entry_pte_q [`TLB_ENTRIES];
  logic [`TLB_ENTRIES-1:0] valid_q;
  logic [ptr_w-1:0]        fill_ptr_q;
  logic                    hit_q;
  logic                    miss_q;
  pte_t                    pte_q;

  logic match;
  pte_t match_pte;

  always_comb begin
    match     = 1'b0;
    match_pte = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (valid_q[i] && (tag_q[i] == lookup_vtag_i)) begin
        match     = 1'b1;
        match_pte = entry_pte_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q    <= '0;
      fill_ptr_q <= '0;
      hit_q      <= 1'b0;
      miss_q     <= 1'b0;
    end else begin
      hit_q  <= lookup_v_i & match;
      miss_q <= lookup_v_i & ~match;
      if (flush_i) begin
        valid_q <= '0;
      end else if (fill_v_i) begin
        valid_q[fill_ptr_q] <= 1'b1;
        fill_ptr_q          <= fill_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_q[fill_ptr_q]       <= fill_vtag_i;
      entry_pte_q[fill_ptr_q] <= fill_pte_i;
    end
    if (lookup_v_i) begin
      pte_q <= match_pte;
    end
  end

  assign hit_o  = hit_q;
  assign miss_o = miss_q;
  assign pte_o  = pte_q;

endmodule

`default_nettype wire

// ==== lsu_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_macros.svh"

module lsu_pipe
  (input  logic                   clk_i
  , input  logic                  reset_i
  , input  logic                  translation_en_i
  , input  mem_pkg::priv_t        priv_i
  , input  logic                  sum_i
  , input  logic                  domain_w_v_i
  , input  mem_pkg::domain_mask_t domain_i
  , output mem_pkg::domain_mask_t domain_o
  , input  logic                  cmd_v_i
  , input  logic                  cmd_store_i
  , input  mem_pkg::vaddr_t       cmd_vaddr_i
  , input  mem_pkg::word_t        cmd_data_i
  , output logic                  cmd_ready_o
  , output logic                  resp_v_o
  , output mem_pkg::exc_t         resp_exc_o
  , output mem_pkg::word_t        resp_data_o
  , output logic                  tlb_lookup_v_o
  , output mem_pkg::vtag_t        tlb_vtag_o
  , input  logic                  tlb_hit_i
  , input  logic                  tlb_miss_i
  , input  mem_pkg::pte_t         tlb_pte_i
  , output logic                  walk_start_o
  , output mem_pkg::vtag_t        walk_vtag_o
  , input  logic                  walk_busy_i
  , input  logic                  walk_done_i
  , input  logic                  walk_fault_i
  , output logic                  mem_req_o
  , output logic                  mem_we_o
  , output mem_pkg::mem_addr_t    mem_addr_o
  , output mem_pkg::word_t        mem_wdata_o
  , input  logic                  mem_gnt_i
  , input  logic                  mem_rvalid_i
  , input  mem_pkg::word_t        mem_rdata_i
  );

  import mem_pkg::*;

  logic         s2_v_q;
  logic         s2_store_q;
  logic         s2_xlate_q;
  vaddr_t       s2_vaddr_q;
  word_t        s2_data_q;
  logic         replay_q;
  logic         resp_v_q;
  exc_t         resp_exc_q;
  domain_mask_t domain_q;

  logic   accept;
  vtag_t  s2_vtag;
  logic   walk_fail;
  logic   s2_chk;
  logic   perm_fault;
  logic   page_fault;
  logic   access_fault;
  logic   s2_go;
  paddr_t paddr;
  exc_t   s2_exc;

  // Stage 1: accept and look up
  assign accept  = cmd_v_i & cmd_ready_o;
  assign s2_vtag = s2_vaddr_q[`VADDR_W-1:`PAGE_OFF_W];

  // After a good walk the stalled command looks up again
  assign tlb_lookup_v_o = accept | replay_q;
  assign tlb_vtag_o     = replay_q ? s2_vtag : cmd_vaddr_i[`VADDR_W-1:`PAGE_OFF_W];

  // Stage 2: translate, check, access
  assign walk_fail = walk_done_i & walk_fault_i;
  assign s2_chk    = s2_v_q & (~s2_xlate_q | tlb_hit_i | walk_fail);

  assign paddr = s2_xlate_q ?
                 {tlb_pte_i[`PTE_PPN_LSB +: (`PADDR_W-`PAGE_OFF_W)],
                  s2_vaddr_q[`PAGE_OFF_W-1:0]} :
                 s2_vaddr_q[`PADDR_W-1:0];

  assign perm_fault = ((priv_i == `PRIV_U) & ~tlb_pte_i[`PTE_U])
                    | ((priv_i == `PRIV_S) & tlb_pte_i[`PTE_U] & ~sum_i)
                    | (~s2_store_q & ~tlb_pte_i[`PTE_R])
                    | (s2_store_q & (~tlb_pte_i[`PTE_W] | ~tlb_pte_i[`PTE_D]));

  assign page_fault   = walk_fail | (s2_xlate_q & tlb_hit_i & perm_fault);
  assign access_fault = ~domain_q[paddr[`PADDR_W-1 -: `DOMAIN_W]];

  always_comb begin
    if (page_fault) begin
      s2_exc = s2_store_q ? `EXC_STORE_PF : `EXC_LOAD_PF;
    end else if (access_fault) begin
      s2_exc = s2_store_q ? `EXC_STORE_AF : `EXC_LOAD_AF;
    end else begin
      s2_exc = `EXC_NONE;
    end
  end

  assign mem_req_o   = s2_chk & ~page_fault & ~access_fault;
  assign mem_we_o    = s2_store_q;
  assign mem_addr_o  = paddr[`PADDR_W-1:2];
  assign mem_wdata_o = s2_data_q;

  assign s2_go = s2_chk & (page_fault | access_fault | mem_gnt_i);

  assign walk_start_o = s2_v_q & s2_xlate_q & tlb_miss_i;
  assign walk_vtag_o  = s2_vtag;

  assign cmd_ready_o = (~s2_v_q | s2_go) & ~walk_busy_i & ~replay_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s2_v_q   <= 1'b0;
      replay_q <= 1'b0;
      resp_v_q <= 1'b0;
      domain_q <= domain_mask_t'(1);
    end else begin
      if (accept) begin
        s2_v_q <= 1'b1;
      end else if (s2_go) begin
        s2_v_q <= 1'b0;
      end
      replay_q <= walk_done_i & ~walk_fault_i;
      resp_v_q <= s2_go;
      // Domain 0 stays enabled
      if (domain_w_v_i) begin
        domain_q <= domain_i | domain_mask_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      s2_store_q <= cmd_store_i;
      s2_xlate_q <= translation_en_i;
      s2_vaddr_q <= cmd_vaddr_i;
      s2_data_q  <= cmd_data_i;
    end
    if (s2_go) begin
      resp_exc_q <= s2_exc;
    end
  end

  assign resp_v_o    = resp_v_q;
  assign resp_exc_o  = resp_exc_q;
  assign resp_data_o = mem_rvalid_i ? mem_rdata_i : '0;
  assign domain_o    = domain_q;

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
  (input  logic                clk_i
  , input  logic               reset_i
  , input  logic               walk_req_i
  , input  mem_pkg::mem_addr_t walk_addr_i
  , output logic               walk_gnt_o
  , output logic               walk_rvalid_o
  , input  logic               lsu_req_i
  , input  logic               lsu_we_i
  , input  mem_pkg::mem_addr_t lsu_addr_i
  , input  mem_pkg::word_t     lsu_wdata_i
  , output logic               lsu_gnt_o
  , output logic               lsu_rvalid_o
  , output logic               mem_en_o
  , output logic               mem_we_o
  , output mem_pkg::mem_addr_t mem_addr_o
  , output mem_pkg::word_t     mem_wdata_o
  );

  logic walk_rd_q;
  logic lsu_rd_q;

  // Walker always wins
  assign walk_gnt_o = walk_req_i;
  assign lsu_gnt_o  = lsu_req_i & ~walk_req_i;

  assign mem_en_o    = walk_req_i | lsu_req_i;
  assign mem_we_o    = lsu_gnt_o & lsu_we_i;
  assign mem_addr_o  = walk_req_i ? walk_addr_i : lsu_addr_i;
  assign mem_wdata_o = lsu_wdata_i;

  // Owner of the read whose data comes back next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      walk_rd_q <= 1'b0;
      lsu_rd_q  <= 1'b0;
    end else begin
      walk_rd_q <= walk_gnt_o;
      lsu_rd_q  <= lsu_gnt_o & ~lsu_we_i;
    end
  end

  assign walk_rvalid_o = walk_rd_q;
  assign lsu_rvalid_o  = lsu_rd_q;

endmodule

`default_nettype wire

// ==== mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Address and data widths
`define VADDR_W      16
`define PADDR_W      14
`define PAGE_OFF_W   8
`define VPN_IDX_W    4
`define WORD_W       32
`define MEM_WORDS    4096
`define TLB_ENTRIES  4
`define DOMAIN_W     2

// PTE bit positions
`define PTE_V        0
`define PTE_R        1
`define PTE_W        2
`define PTE_U        4
`define PTE_D        7
`define PTE_PPN_LSB  10

`define PRIV_U       2'd0
`define PRIV_S       2'd1
`define PRIV_M       2'd3

`define EXC_NONE     3'd0
`define EXC_LOAD_PF  3'd1
`define EXC_STORE_PF 3'd2
`define EXC_LOAD_AF  3'd3
`define EXC_STORE_AF 3'd4

`endif

// ==== mem_pkg.sv ====
`default_nettype none
`include "mem_macros.svh"

package mem_pkg;

  typedef logic [`VADDR_W-1:0]              vaddr_t;
  typedef logic [`PADDR_W-1:0]              paddr_t;
  typedef logic [`VADDR_W-`PAGE_OFF_W-1:0]  vtag_t;
  typedef logic [`PADDR_W-`PAGE_OFF_W-1:0]  ptag_t;

  typedef logic [`WORD_W-1:0]               word_t;
  typedef logic [`WORD_W-1:0]               pte_t;
  // Word index into the data memory
  typedef logic [`PADDR_W-3:0]              mem_addr_t;

  typedef logic [1:0]                       priv_t;
  typedef logic [2:0]                       exc_t;
  typedef logic [(1 << `DOMAIN_W)-1:0]      domain_mask_t;

  typedef enum logic [1:0] {
    e_walk_idle,
    e_walk_level1,
    e_walk_level0,
    e_walk_done
  } walk_state_e;

endpackage

`default_nettype wire

// ==== mem_unit_properties.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_macros.svh"

module mem_unit_properties
  (input  logic                  clk_i
  , input  logic                  reset_i
  , input  logic                  translation_en_i
  , input  logic                  cmd_v_i
  , input  logic                  cmd_ready_i
  , input  logic                  resp_v_i
  , input  mem_pkg::exc_t         resp_exc_i
  , input  mem_pkg::word_t        resp_data_i
  , input  mem_pkg::domain_mask_t domain_i
  , input  logic                  walk_busy_i
  , input  logic                  walk_done_i
  , input  logic                  walk_fault_i
  );

  import mem_pkg::*;

  int fail_count = 0;
  int outstanding_q;

  // Commands accepted but not yet answered
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 0;
    end else begin
      outstanding_q <= outstanding_q + int'(cmd_v_i && cmd_ready_i) - int'(resp_v_i);
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> (!resp_v_i && cmd_ready_i))
    else begin $error("resp_v_o or cmd_ready_o wrong after reset"); fail_count++; end

  a_bare_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_v_i && cmd_ready_i && !translation_en_i) |-> ##2 resp_v_i)
    else begin $error("bare command did not respond two cycles later"); fail_count++; end

  a_resp_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i |-> (outstanding_q != 0))
    else begin $error("response without an accepted command"); fail_count++; end

  a_fault_zero_data: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_i && resp_exc_i != `EXC_NONE) |-> (resp_data_i == '0))
    else begin $error("faulting response carries data"); fail_count++; end

  a_domain0: assert property (@(posedge clk_i) disable iff (reset_i)
    domain_i[0])
    else begin $error("domain 0 disabled"); fail_count++; end

  // Only the stalled command is in flight during a walk
  a_walk_alone: assert property (@(posedge clk_i) disable iff (reset_i)
    walk_busy_i |-> (!resp_v_i && outstanding_q == 1))
    else begin $error("response or second command during a walk"); fail_count++; end

  // Failed walk ends the command with a page fault
  a_walk_fault_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    (walk_done_i && walk_fault_i) |=>
      (resp_v_i && (resp_exc_i == `EXC_LOAD_PF || resp_exc_i == `EXC_STORE_PF)))
    else begin $error("walk fault gave no page fault response"); fail_count++; end

endmodule

bind mem_unit_top mem_unit_properties u_props
  (.clk_i(clk_i)
  , .reset_i(reset_i)
  , .translation_en_i(translation_en_i)
  , .cmd_v_i(cmd_v_i)
  , .cmd_ready_i(cmd_ready_o)
  , .resp_v_i(resp_v_o)
  , .resp_exc_i(resp_exc_o)
  , .resp_data_i(resp_data_o)
  , .domain_i(domain_o)
  , .walk_busy_i(walk_busy)
  , .walk_done_i(walk_done)
  , .walk_fault_i(walk_fault)
  );

`default_nettype wire

// ==== mem_unit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_unit_top
  (input  logic                   clk_i
  , input  logic                  reset_i
  , input  logic                  translation_en_i
  , input  mem_pkg::priv_t        priv_i
  , input  logic                  sum_i
  , input  mem_pkg::ptag_t        base_ppn_i
  , input  logic                  cmd_v_i
  , input  logic                  cmd_store_i
  , input  mem_pkg::vaddr_t       cmd_vaddr_i
  , input  mem_pkg::word_t        cmd_data_i
  , output logic                  cmd_ready_o
  , input  logic                  flush_i
  , input  logic                  domain_w_v_i
  , input  mem_pkg::domain_mask_t domain_i
  , output logic                  resp_v_o
  , output mem_pkg::exc_t         resp_exc_o
  , output mem_pkg::word_t        resp_data_o
  , output mem_pkg::domain_mask_t domain_o
  );

  import mem_pkg::*;

  logic      tlb_lookup_v;
  vtag_t     tlb_vtag;
  logic      tlb_hit;
  logic      tlb_miss;
  pte_t      tlb_pte;
  logic      fill_v;
  vtag_t     fill_vtag;
  pte_t      fill_pte;

  logic      walk_start;
  vtag_t     walk_vtag;
  logic      walk_busy;
  logic      walk_done;
  logic      walk_fault;

  logic      walk_req;
  mem_addr_t walk_addr;
  logic      walk_gnt;
  logic      walk_rvalid;
  logic      lsu_req;
  logic      lsu_we;
  mem_addr_t lsu_addr;
  word_t     lsu_wdata;
  logic      lsu_gnt;
  logic      lsu_rvalid;

  logic      mem_en;
  logic      mem_we;
  mem_addr_t mem_addr;
  word_t     mem_wdata;
  word_t     mem_rdata;

  lsu_pipe u_lsu
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .translation_en_i(translation_en_i)
    , .priv_i(priv_i)
    , .sum_i(sum_i)
    , .domain_w_v_i(domain_w_v_i)
    , .domain_i(domain_i)
    , .domain_o(domain_o)
    , .cmd_v_i(cmd_v_i)
    , .cmd_store_i(cmd_store_i)
    , .cmd_vaddr_i(cmd_vaddr_i)
    , .cmd_data_i(cmd_data_i)
    , .cmd_ready_o(cmd_ready_o)
    , .resp_v_o(resp_v_o)
    , .resp_exc_o(resp_exc_o)
    , .resp_data_o(resp_data_o)
    , .tlb_lookup_v_o(tlb_lookup_v)
    , .tlb_vtag_o(tlb_vtag)
    , .tlb_hit_i(tlb_hit)
    , .tlb_miss_i(tlb_miss)
    , .tlb_pte_i(tlb_pte)
    , .walk_start_o(walk_start)
    , .walk_vtag_o(walk_vtag)
    , .walk_busy_i(walk_busy)
    , .walk_done_i(walk_done)
    , .walk_fault_i(walk_fault)
    , .mem_req_o(lsu_req)
    , .mem_we_o(lsu_we)
    , .mem_addr_o(lsu_addr)
    , .mem_wdata_o(lsu_wdata)
    , .mem_gnt_i(lsu_gnt)
    , .mem_rvalid_i(lsu_rvalid)
    , .mem_rdata_i(mem_rdata)
    );

  dtlb u_dtlb
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .flush_i(flush_i)
    , .lookup_v_i(tlb_lookup_v)
    , .lookup_vtag_i(tlb_vtag)
    , .hit_o(tlb_hit)
    , .miss_o(tlb_miss)
    , .pte_o(tlb_pte)
    , .fill_v_i(fill_v)
    , .fill_vtag_i(fill_vtag)
    , .fill_pte_i(fill_pte)
    );

  page_walker u_walker
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .base_ppn_i(base_ppn_i)
    , .start_i(walk_start)
    , .vtag_i(walk_vtag)
    , .busy_o(walk_busy)
    , .done_o(walk_done)
    , .fault_o(walk_fault)
    , .fill_v_o(fill_v)
    , .fill_vtag_o(fill_vtag)
    , .fill_pte_o(fill_pte)
    , .mem_req_o(walk_req)
    , .mem_addr_o(walk_addr)
    , .mem_gnt_i(walk_gnt)
    , .mem_rvalid_i(walk_rvalid)
    , .mem_rdata_i(mem_rdata)
    );

  mem_arbiter u_arb
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .walk_req_i(walk_req)
    , .walk_addr_i(walk_addr)
    , .walk_gnt_o(walk_gnt)
    , .walk_rvalid_o(walk_rvalid)
    , .lsu_req_i(lsu_req)
    , .lsu_we_i(lsu_we)
    , .lsu_addr_i(lsu_addr)
    , .lsu_wdata_i(lsu_wdata)
    , .lsu_gnt_o(lsu_gnt)
    , .lsu_rvalid_o(lsu_rvalid)
    , .mem_en_o(mem_en)
    , .mem_we_o(mem_we)
    , .mem_addr_o(mem_addr)
    , .mem_wdata_o(mem_wdata)
    );

  data_mem u_mem
    (.clk_i(clk_i)
    , .en_i(mem_en)
    , .we_i(mem_we)
    , .addr_i(mem_addr)
    , .wdata_i(mem_wdata)
    , .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

// ==== page_walker.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_macros.svh"

module page_walker
  (input  logic                clk_i
  , input  logic               reset_i
  , input  mem_pkg::ptag_t     base_ppn_i
  , input  logic               start_i
  , input  mem_pkg::vtag_t     vtag_i
  , output logic               busy_o
  , output logic               done_o
  , output logic               fault_o
  , output logic               fill_v_o
  , output mem_pkg::vtag_t     fill_vtag_o
  , output mem_pkg::pte_t      fill_pte_o
  , output logic               mem_req_o
  , output mem_pkg::mem_addr_t mem_addr_o
  , input  logic               mem_gnt_i
  , input  logic               mem_rvalid_i
  , input  mem_pkg::word_t     mem_rdata_i
  );

  import mem_pkg::*;

  walk_state_e state_q;
  vtag_t       vtag_q;
  ptag_t       table_ppn_q;
  pte_t        pte_q;
  logic        issued_q;
  logic        fault_q;

  ptag_t                 table_ppn;
  logic [`VPN_IDX_W-1:0] index;
  pte_t                  rd_pte;
  logic                  reading;
  logic                  ptr_ok;
  logic                  leaf_ok;

  assign rd_pte  = mem_rdata_i;
  assign reading = (state_q == e_walk_level1) || (state_q == e_walk_level0);

  // Pointer PTE has V only, leaf PTE needs V and R
  assign ptr_ok  = rd_pte[`PTE_V] & ~rd_pte[`PTE_R] & ~rd_pte[`PTE_W];
  assign leaf_ok = rd_pte[`PTE_V] & rd_pte[`PTE_R];

  always_comb begin
    if (state_q == e_walk_level1) begin
      table_ppn = base_ppn_i;
      index     = vtag_q[2*`VPN_IDX_W-1 -: `VPN_IDX_W];
    end else begin
      table_ppn = table_ppn_q;
      index     = vtag_q[`VPN_IDX_W-1:0];
    end
  end

  // Four bytes per PTE inside the table page
  assign mem_addr_o = {table_ppn, {(`PAGE_OFF_W-`VPN_IDX_W-2){1'b0}}, index};
  assign mem_req_o  = reading & ~issued_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= e_walk_idle;
      issued_q <= 1'b0;
      fault_q  <= 1'b0;
    end else begin
      case (state_q)
        e_walk_idle: begin
          fault_q <= 1'b0;
          if (start_i) begin
            state_q <= e_walk_level1;
          end
        end
        e_walk_level1,
        e_walk_level0: begin
          if (mem_req_o && mem_gnt_i) begin
            issued_q <= 1'b1;
          end
          if (mem_rvalid_i) begin
            issued_q <= 1'b0;
            if (state_q == e_walk_level1 && ptr_ok) begin
              state_q <= e_walk_level0;
            end else begin
              state_q <= e_walk_done;
              fault_q <= (state_q == e_walk_level1) | ~leaf_ok;
            end
          end
        end
        default: state_q <= e_walk_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == e_walk_idle && start_i) begin
      vtag_q <= vtag_i;
    end
    if (mem_rvalid_i && state_q == e_walk_level1) begin
      table_ppn_q <= rd_pte[`PTE_PPN_LSB +: (`PADDR_W-`PAGE_OFF_W)];
    end
    if (mem_rvalid_i && state_q == e_walk_level0) begin
      pte_q <= rd_pte;
    end
  end

  assign busy_o      = state_q != e_walk_idle;
  assign done_o      = state_q == e_walk_done;
  assign fault_o     = done_o & fault_q;
  assign fill_v_o    = done_o & ~fault_q;
  assign fill_vtag_o = vtag_q;
  assign fill_pte_o  = pte_q;

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
mem_pkg.sv
data_mem.sv
mem_arbiter.sv
dtlb.sv
page_walker.sv
lsu_pipe.sv
mem_unit_top.sv
mem_unit_properties.sv
tb_top.sv

// ==== tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "mem_macros.svh"

module tb_top;

  import mem_pkg::*;

  localparam int max_cycles = 4000;

  logic         clk_i = 1'b0;
  logic         reset_i;
  logic         translation_en_i;
  priv_t        priv_i;
  logic         sum_i;
  ptag_t        base_ppn_i;
  logic         cmd_v_i;
  logic         cmd_store_i;
  vaddr_t       cmd_vaddr_i;
  word_t        cmd_data_i;
  logic         cmd_ready_o;
  logic         flush_i;
  logic         domain_w_v_i;
  domain_mask_t domain_i;
  logic         resp_v_o;
  exc_t         resp_exc_o;
  word_t        resp_data_o;
  domain_mask_t domain_o;

  logic [31:0] rng_q = 32'hd299;
  int          cycle_q = 0;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          test_start_errs;

  // Expected responses in acceptance order
  exc_t        exp_exc_q [$];
  word_t       exp_data_q [$];
  // Set for a TLB-free command, clear for one that walks first
  logic        exp_lat_q [$];
  realtime     exp_time_q [$];
  word_t       shadow [int];

  exc_t        mon_exc;
  word_t       mon_data;
  logic        mon_lat;
  realtime     mon_time;
  realtime     mon_wait;

  mem_unit_top u_dut
    (.clk_i(clk_i)
    , .reset_i(reset_i)
    , .translation_en_i(translation_en_i)
    , .priv_i(priv_i)
    , .sum_i(sum_i)
    , .base_ppn_i(base_ppn_i)
    , .cmd_v_i(cmd_v_i)
    , .cmd_store_i(cmd_store_i)
    , .cmd_vaddr_i(cmd_vaddr_i)
    , .cmd_data_i(cmd_data_i)
    , .cmd_ready_o(cmd_ready_o)
    , .flush_i(flush_i)
    , .domain_w_v_i(domain_w_v_i)
    , .domain_i(domain_i)
    , .resp_v_o(resp_v_o)
    , .resp_exc_o(resp_exc_o)
    , .resp_data_o(resp_data_o)
    , .domain_o(domain_o)
    );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_q <= cycle_q + 1;
    if (cycle_q >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Test failed");
      $finish;
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i && resp_v_o) begin
      if (exp_exc_q.size() == 0) begin
        $display("A response arrived with no command outstanding");
        errors++;
      end else begin
        mon_exc  = exp_exc_q.pop_front();
        mon_data = exp_data_q.pop_front();
        mon_lat  = exp_lat_q.pop_front();
        mon_time = exp_time_q.pop_front();
        mon_wait = ($realtime - mon_time) / 8.0;
        assert (resp_exc_o == mon_exc) else begin
          $display("[ERROR] resp_exc_o: expected 0x%0h, got 0x%0h", mon_exc, resp_exc_o);
          errors++;
        end
        assert (resp_data_o == mon_data) else begin
          $display("[ERROR] resp_data_o: expected 0x%0h, got 0x%0h", mon_data, resp_data_o);
          errors++;
        end
        assert (mon_lat ? (mon_wait == 2.0) : (mon_wait > 2.0)) else begin
          if (mon_lat) begin
            $display("Response latency was %0.0f cycles instead of 2", mon_wait);
          end else begin
            $display("Response came after %0.0f cycles, too soon for a table walk", mon_wait);
          end
          errors++;
        end
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] make_pte(input logic [5:0] ppn, input logic [7:0] flags);
    return (32'(ppn) << `PTE_PPN_LSB) | 32'(flags);
  endfunction

  function automatic int total_errors();
    return errors + u_dut.u_props.fail_count;
  endfunction

  task automatic issue(input logic store, input logic [15:0] va, input word_t wd,
                       input exc_t exc, input word_t rd, input logic chk_lat);
    cmd_v_i     <= 1'b1;
    cmd_store_i <= store;
    cmd_vaddr_i <= va;
    cmd_data_i  <= wd;
    do @(posedge clk_i); while (!cmd_ready_o);
    exp_exc_q.push_back(exc);
    exp_data_q.push_back(rd);
    exp_lat_q.push_back(chk_lat);
    exp_time_q.push_back($realtime);
  endtask

  task automatic drain();
    cmd_v_i <= 1'b0;
    @(posedge clk_i);
    while (exp_exc_q.size() != 0) @(posedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic set_mode(input logic xlate, input priv_t priv, input logic sum);
    drain();
    translation_en_i <= xlate;
    priv_i           <= priv;
    sum_i            <= sum;
  endtask

  task automatic bare_store(input logic [13:0] pa, input word_t d);
    issue(1'b1, 16'(pa), d, `EXC_NONE, '0, 1'b1);
    shadow[int'(pa)] = d;
  endtask

  task automatic bare_load(input logic [13:0] pa);
    issue(1'b0, 16'(pa), '0, `EXC_NONE, shadow[int'(pa)], 1'b1);
  endtask

  // Translated access that maps to physical address pa
  task automatic xstore(input logic [15:0] va, input logic [13:0] pa, input word_t d,
                        input logic hit);
    issue(1'b1, va, d, `EXC_NONE, '0, hit);
    shadow[int'(pa)] = d;
  endtask

  task automatic xload(input logic [15:0] va, input logic [13:0] pa, input logic hit);
    issue(1'b0, va, '0, `EXC_NONE, shadow[int'(pa)], hit);
  endtask

  task automatic write_domain(input domain_mask_t m, input domain_mask_t exp);
    domain_w_v_i <= 1'b1;
    domain_i     <= m;
    @(posedge clk_i);
    domain_w_v_i <= 1'b0;
    @(posedge clk_i);
    @(posedge clk_i);
    assert (domain_o == exp) else begin
      $display("[ERROR] domain_o: expected 0x%0h, got 0x%0h", exp, domain_o);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    drain();
    if (total_errors() == test_start_errs) begin
      passed++;
      $display("%s: pass", name);
    end else begin
      failed++;
      $display("%s: FAIL", name);
    end
    test_start_errs = total_errors();
  endtask

  initial begin
    logic [13:0] addrs [8];
    reset_i          = 1'b1;
    translation_en_i = 1'b0;
    priv_i           = `PRIV_M;
    sum_i            = 1'b0;
    base_ppn_i       = 6'h04;
    cmd_v_i          = 1'b0;
    cmd_store_i      = 1'b0;
    cmd_vaddr_i      = '0;
    cmd_data_i       = '0;
    flush_i          = 1'b0;
    domain_w_v_i     = 1'b0;
    domain_i         = '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    test_start_errs = total_errors();

    // Random bare stores then loads, back to back
    for (int i = 0; i < 8; i++) begin
      rng_q = xorshift(rng_q);
      addrs[i] = {4'h0, rng_q[7:0], 2'b00};
      rng_q = xorshift(rng_q);
      bare_store(addrs[i], rng_q);
    end
    for (int i = 0; i < 8; i++) begin
      bare_load(addrs[i]);
    end
    end_test("bare store and load");

    // Level 1 at 0x400, level 0 table for upper index 1 at 0x500
    bare_store(14'h404, make_pte(6'h05, 8'h01));
    bare_store(14'h408, make_pte(6'h06, 8'h03));
    bare_store(14'h500, make_pte(6'h08, 8'h87));
    bare_store(14'h504, make_pte(6'h09, 8'h03));
    bare_store(14'h508, make_pte(6'h0a, 8'h07));
    bare_store(14'h50c, make_pte(6'h0b, 8'h87));
    bare_store(14'h510, make_pte(6'h0c, 8'h97));
    bare_store(14'h514, make_pte(6'h0c, 8'h96));
    bare_store(14'h518, make_pte(6'h20, 8'h87));
    bare_store(14'h51c, make_pte(6'h0d, 8'h87));
    set_mode(1'b1, `PRIV_M, 1'b0);
    rng_q = xorshift(rng_q);
    xstore(16'h1024, 14'h0824, rng_q, 1'b0);
    xload(16'h1024, 14'h0824, 1'b1);
    rng_q = xorshift(rng_q);
    xstore(16'h1048, 14'h0848, rng_q, 1'b1);
    xload(16'h1048, 14'h0848, 1'b1);
    set_mode(1'b0, `PRIV_M, 1'b0);
    bare_load(14'h0824);
    bare_load(14'h0848);
    end_test("translated access");

    bare_store(14'h0924, 32'h1111_2222);
    bare_store(14'h0a24, 32'h3333_4444);
    bare_store(14'h0c40, 32'h5555_6666);
    set_mode(1'b1, `PRIV_M, 1'b0);
    issue(1'b1, 16'h1124, 32'hdead_0001, `EXC_STORE_PF, '0, 1'b0);
    issue(1'b1, 16'h1224, 32'hdead_0002, `EXC_STORE_PF, '0, 1'b0);
    set_mode(1'b1, `PRIV_U, 1'b0);
    issue(1'b0, 16'h1330, '0, `EXC_LOAD_PF, '0, 1'b0);
    set_mode(1'b1, `PRIV_S, 1'b0);
    issue(1'b0, 16'h1440, '0, `EXC_LOAD_PF, '0, 1'b0);
    set_mode(1'b1, `PRIV_S, 1'b1);
    xload(16'h1440, 14'h0c40, 1'b1);
    set_mode(1'b0, `PRIV_M, 1'b0);
    bare_load(14'h0924);
    bare_load(14'h0a24);
    end_test("permissions");

    set_mode(1'b1, `PRIV_M, 1'b0);
    issue(1'b0, 16'h1500, '0, `EXC_LOAD_PF, '0, 1'b0);
    issue(1'b1, 16'h1504, 32'hbad0_0001, `EXC_STORE_PF, '0, 1'b0);
    issue(1'b0, 16'h2000, '0, `EXC_LOAD_PF, '0, 1'b0);
    issue(1'b1, 16'h2010, 32'hbad0_0002, `EXC_STORE_PF, '0, 1'b0);
    end_test("bad page table");

    // Physical page 0x20 lies in domain 2
    set_mode(1'b0, `PRIV_M, 1'b0);
    issue(1'b1, 16'h2010, 32'hbad0_0003, `EXC_STORE_AF, '0, 1'b1);
    set_mode(1'b1, `PRIV_M, 1'b0);
    issue(1'b0, 16'h1610, '0, `EXC_LOAD_AF, '0, 1'b0);
    drain();
    write_domain(4'b0100, 4'b0101);
    rng_q = xorshift(rng_q);
    xstore(16'h1610, 14'h2010, rng_q, 1'b1);
    xload(16'h1610, 14'h2010, 1'b1);
    drain();
    write_domain(4'b0000, 4'b0001);
    end_test("domains");

    set_mode(1'b0, `PRIV_M, 1'b0);
    bare_store(14'h0d00, 32'haaaa_0d00);
    bare_store(14'h0e00, 32'hbbbb_0e00);
    set_mode(1'b1, `PRIV_M, 1'b0);
    xload(16'h1700, 14'h0d00, 1'b0);
    set_mode(1'b0, `PRIV_M, 1'b0);
    bare_store(14'h051c, make_pte(6'h0e, 8'h87));
    set_mode(1'b1, `PRIV_M, 1'b0);
    xload(16'h1700, 14'h0d00, 1'b1);
    drain();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    xload(16'h1700, 14'h0e00, 1'b0);
    end_test("flush");

    $display("tests: %0d passed, %0d failed, %0d errors", passed, failed, total_errors());
    if (failed == 0 && total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
